//--- eeprom_defs.svh
`ifndef EEPROM_DEFS_SVH
`define EEPROM_DEFS_SVH

// clk cycles per bit engine step
`define I2C_STEP_DIV 50

// width of the step divider count
`define I2C_DIV_W 6

// fixed EEPROM slave address
`define I2C_DEV_ADDR 7'h23

`define I2C_ADDR_W 8
`define I2C_DATA_W 8

`endif

//--- i2c_pkg.sv
package i2c_pkg;

        typedef enum logic [2:0] {
                OP_START_WRITE,         // start, then one byte out
                OP_WRITE,
                OP_RESTART_WRITE,       // repeated start, then one byte out
                OP_READ_ACK,
                OP_READ_NACK,
                OP_STOP
        } byte_op_t;

        typedef enum logic [2:0] {
                ST_IDLE,
                ST_DEV_WR,
                ST_WORD_ADDR,
                ST_DATA_WR,
                ST_DEV_RD,
                ST_RD_HI,
                ST_RD_LO,
                ST_STOP
        } seq_state_t;

        typedef enum logic [2:0] {
                PH_IDLE,
                PH_START,
                PH_BITS,
                PH_ACK,
                PH_STOP
        } bit_phase_t;

endpackage

//--- i2c_byte_if.sv
`include "eeprom_defs.svh"

interface i2c_byte_if;
        import i2c_pkg::*;

        logic                   op_valid;
        byte_op_t               op;
        logic [`I2C_DATA_W-1:0] tx_byte;
        logic                   op_done;
        logic                   ack;    // slave pulled sda low on a write byte
        logic [`I2C_DATA_W-1:0] rx_byte;

        modport seq (
                output op_valid,
                output op,
                output tx_byte,
                input  op_done,
                input  ack,
                input  rx_byte
        );

        modport eng (
                input  op_valid,
                input  op,
                input  tx_byte,
                output op_done,
                output ack,
                output rx_byte
        );

endinterface

//--- i2c_sequencer.sv
`include "eeprom_defs.svh"

module i2c_sequencer (
        input  logic                     clk,
        input  logic                     rstn,
        input  logic                     start,
        input  logic                     wr,
        input  logic                     rd,
        input  logic [`I2C_ADDR_W-1:0]   addr,
        input  logic [`I2C_DATA_W-1:0]   data_wr,
        output logic [2*`I2C_DATA_W-1:0] data_rd,
        output logic                     done,
        output logic                     ack,
        i2c_byte_if.seq                  bus
);
        import i2c_pkg::*;

        seq_state_t             state;
        seq_state_t             state_nxt;
        logic                   is_rd;
        logic [`I2C_ADDR_W-1:0] addr_q;
        logic [`I2C_DATA_W-1:0] data_q;

        assign ack = bus.ack;

        // the operation on the bus follows the current state
        always_comb
        begin
                state_nxt   = ST_IDLE;
                bus.op      = OP_STOP;
                bus.tx_byte = '0;
                case (state)
                ST_IDLE:
                        state_nxt = ST_DEV_WR;
                ST_DEV_WR:
                begin
                        state_nxt   = ST_WORD_ADDR;
                        bus.op      = OP_START_WRITE;
                        bus.tx_byte = {`I2C_DEV_ADDR, 1'b0};
                end
                ST_WORD_ADDR:
                begin
                        state_nxt   = is_rd ? ST_DEV_RD : ST_DATA_WR;
                        bus.op      = OP_WRITE;
                        bus.tx_byte = addr_q;
                end
                ST_DATA_WR:
                begin
                        state_nxt   = ST_STOP;
                        bus.op      = OP_WRITE;
                        bus.tx_byte = data_q;
                end
                ST_DEV_RD:
                begin
                        state_nxt   = ST_RD_HI;
                        bus.op      = OP_RESTART_WRITE;
                        bus.tx_byte = {`I2C_DEV_ADDR, 1'b1};
                end
                ST_RD_HI:
                begin
                        state_nxt   = ST_RD_LO;
                        bus.op      = OP_READ_ACK;
                        bus.tx_byte = '1;       // sda left released
                end
                ST_RD_LO:
                begin
                        state_nxt   = ST_STOP;
                        bus.op      = OP_READ_NACK;
                        bus.tx_byte = '1;
                end
                ST_STOP:
                        state_nxt = ST_IDLE;
                endcase
        end

        always_ff @(posedge clk or negedge rstn)
        begin
                if (!rstn)
                begin
                        state        <= ST_IDLE;
                        is_rd        <= 1'b0;
                        bus.op_valid <= 1'b0;
                        done         <= 1'b0;
                        data_rd      <= '0;
                end
                else
                begin
                        bus.op_valid <= 1'b0;
                        done         <= 1'b0;
                        if (state == ST_IDLE)
                        begin
                                if (start && (wr || rd))
                                begin
                                        is_rd        <= ~wr;    // write wins
                                        state        <= state_nxt;
                                        bus.op_valid <= 1'b1;
                                end
                        end
                        else if (bus.op_done)
                        begin
                                state        <= state_nxt;
                                bus.op_valid <= (state_nxt != ST_IDLE);
                                done         <= (state == ST_STOP);
                                if (state == ST_RD_HI)
                                        data_rd[2*`I2C_DATA_W-1:`I2C_DATA_W] <= bus.rx_byte;
                                if (state == ST_RD_LO)
                                        data_rd[`I2C_DATA_W-1:0] <= bus.rx_byte;
                        end
                end
        end

        always_ff @(posedge clk)
        begin
                if (state == ST_IDLE && start)
                begin
                        addr_q <= addr;
                        data_q <= data_wr;
                end
        end

        // one op in flight, next op only after the engine reports done
        a_op_valid_src: assert property (@(posedge clk) disable iff (!rstn)
                bus.op_valid |-> !$past(bus.op_valid)
                        && ($past(bus.op_done) || $past(start)));

endmodule

//--- i2c_bit_engine.sv
`include "eeprom_defs.svh"

module i2c_bit_engine (
        input  logic    clk,
        input  logic    rstn,
        output logic    scl,
        output logic    sda_o,
        output logic    sda_oe,
        input  logic    sda_i,
        i2c_byte_if.eng bus
);
        import i2c_pkg::*;

        localparam logic [`I2C_DIV_W-1:0] DIV_LAST  = `I2C_STEP_DIV - 1;
        localparam logic [4:0]            BITS_LAST = 4*`I2C_DATA_W - 1;

        logic [`I2C_DIV_W-1:0]  div_cnt;
        logic                   step;
        bit_phase_t             phase;
        logic [4:0]             step_cnt;
        logic [1:0]             quarter;
        byte_op_t               op_q;
        logic [`I2C_DATA_W-1:0] shift_reg;
        logic                   ack_smp;
        logic                   is_read;
        logic                   has_start;

        assign step      = (div_cnt == DIV_LAST);
        assign quarter   = step_cnt[1:0];       // four steps per scl period
        assign is_read   = op_q inside {OP_READ_ACK, OP_READ_NACK};
        assign has_start = op_q inside {OP_START_WRITE, OP_RESTART_WRITE};

        always_ff @(posedge clk or negedge rstn)
        begin
                if (!rstn)
                        div_cnt <= '0;
                else if (step)
                        div_cnt <= '0;
                else
                        div_cnt <= div_cnt + 1'b1;
        end

        always_ff @(posedge clk or negedge rstn)
        begin
                if (!rstn)
                begin
                        phase       <= PH_IDLE;
                        step_cnt    <= '0;
                        op_q        <= OP_STOP;
                        shift_reg   <= '0;
                        ack_smp     <= 1'b0;
                        scl         <= 1'b1;
                        sda_o       <= 1'b1;
                        sda_oe      <= 1'b1;
                        bus.op_done <= 1'b0;
                        bus.ack     <= 1'b0;
                        bus.rx_byte <= '0;
                end
                else
                begin
                        bus.op_done <= 1'b0;
                        bus.ack     <= 1'b0;
                        if (phase == PH_IDLE)
                        begin
                                if (bus.op_valid)
                                begin
                                        op_q      <= bus.op;
                                        shift_reg <= bus.tx_byte;
                                        step_cnt  <= '0;
                                        if (bus.op == OP_STOP)
                                                phase <= PH_STOP;
                                        else if (bus.op inside {OP_READ_ACK, OP_READ_NACK})
                                                phase <= PH_BITS;
                                        else
                                                phase <= PH_START;
                                end
                        end
                        else if (step)
                        begin
                                step_cnt <= step_cnt + 1'b1;
                                case (phase)
                                PH_START:
                                begin
                                        if (has_start)
                                        begin
                                                case (quarter)
                                                2'd0:
                                                begin
                                                        sda_oe <= 1'b1;
                                                        sda_o  <= 1'b1;
                                                end
                                                2'd1: scl   <= 1'b1;
                                                2'd2: sda_o <= 1'b0;   // start condition
                                                2'd3: scl   <= 1'b0;
                                                endcase
                                        end
                                        if (quarter == 2'd3)
                                        begin
                                                step_cnt <= '0;
                                                phase    <= PH_BITS;
                                        end
                                end
                                PH_BITS:
                                begin
                                        case (quarter)
                                        2'd0:
                                        begin
                                                sda_oe <= ~is_read;
                                                sda_o  <= shift_reg[`I2C_DATA_W-1];
                                        end
                                        2'd1:
                                        begin
                                                scl       <= 1'b1;
                                                shift_reg <= {shift_reg[`I2C_DATA_W-2:0], sda_i};
                                        end
                                        2'd3: scl <= 1'b0;
                                        default: ;
                                        endcase
                                        if (step_cnt == BITS_LAST)
                                                phase <= PH_ACK;
                                end
                                PH_ACK:
                                begin
                                        case (quarter)
                                        2'd0:
                                        begin
                                                sda_oe <= is_read;      // slave acks on writes
                                                sda_o  <= (op_q == OP_READ_NACK);
                                        end
                                        2'd1:
                                        begin
                                                scl     <= 1'b1;
                                                ack_smp <= ~sda_i;
                                        end
                                        2'd3:
                                        begin
                                                scl         <= 1'b0;
                                                phase       <= PH_IDLE;
                                                bus.op_done <= 1'b1;
                                                bus.ack     <= ~is_read & ack_smp;
                                                bus.rx_byte <= shift_reg;
                                        end
                                        default: ;
                                        endcase
                                end
                                PH_STOP:
                                begin
                                        case (step_cnt)
                                        5'd0:
                                        begin
                                                sda_oe <= 1'b1;
                                                sda_o  <= 1'b0;
                                        end
                                        5'd1: scl   <= 1'b1;
                                        5'd3: sda_o <= 1'b1;    // stop condition
                                        5'd15:
                                        begin
                                                phase       <= PH_IDLE;
                                                bus.op_done <= 1'b1;
                                        end
                                        default: ;
                                        endcase
                                end
                                default: ;
                                endcase
                        end
                end
        end

        // driven sda holds while scl stays high, start and stop excepted
        a_sda_stable: assert property (@(posedge clk) disable iff (!rstn)
                (scl && $past(scl) && sda_oe && $past(sda_oe)
                 && !(phase inside {PH_START, PH_STOP})) |-> $stable(sda_o));

        a_op_in_idle: assert property (@(posedge clk) disable iff (!rstn)
                bus.op_valid |-> phase == PH_IDLE);

endmodule

//--- e2prom_ctrl.sv
`include "eeprom_defs.svh"

module e2prom_ctrl (
        input  logic                     clk,
        input  logic                     rstn,
        input  logic                     start,
        input  logic                     wr,
        input  logic                     rd,
        input  logic [`I2C_ADDR_W-1:0]   addr,
        input  logic [`I2C_DATA_W-1:0]   data_wr,
        output logic [2*`I2C_DATA_W-1:0] data_rd,
        output logic                     done,
        output logic                     ack,
        output logic                     scl,
        output logic                     sda_o,
        output logic                     sda_oe,
        input  logic                     sda_i
);

        i2c_byte_if bus ();

        // transaction level, one byte op at a time
        i2c_sequencer u_seq (
                .clk     (clk),
                .rstn    (rstn),
                .start   (start),
                .wr      (wr),
                .rd      (rd),
                .addr    (addr),
                .data_wr (data_wr),
                .data_rd (data_rd),
                .done    (done),
                .ack     (ack),
                .bus     (bus.seq)
        );

        // scl and sda timing
        i2c_bit_engine u_eng (
                .clk    (clk),
                .rstn   (rstn),
                .scl    (scl),
                .sda_o  (sda_o),
                .sda_oe (sda_oe),
                .sda_i  (sda_i),
                .bus    (bus.eng)
        );

endmodule

//--- eeprom_model.sv
`include "eeprom_defs.svh"

module eeprom_model (
        input  logic clk,
        input  logic rstn,
        input  logic mute,
        input  logic scl,
        input  logic sda_o,
        input  logic sda_oe,
        output logic sda_i
);

        typedef enum logic [2:0] {M_IDLE, M_DEV, M_WORD, M_WDATA, M_RDATA} slave_state_t;

        logic [7:0]   mem [0:255];
        slave_state_t st;
        logic [3:0]   cnt;          // bit index, 8 is the ack slot
        logic [7:0]   sh;
        logic [7:0]   tx;
        logic [7:0]   ptr;
        logic         rw;
        logic         pull;         // slave pulls sda low
        logic         m_ack;
        logic         scl_q;
        logic         line_q;
        logic         line;

        assign line  = (sda_oe ? sda_o : 1'b1) & ~pull;     // open drain with pull-up
        assign sda_i = line;

        initial
        begin
                for (int i = 0; i < 256; i++)
                        mem[i] = {i[3:0], i[7:4]} ^ 8'ha5;
        end

        always @(posedge clk or negedge rstn)
        begin
                if (!rstn)
                begin
                        st     <= M_IDLE;
                        cnt    <= '0;
                        pull   <= 1'b0;
                        scl_q  <= 1'b1;
                        line_q <= 1'b1;
                        m_ack  <= 1'b0;
                        ptr    <= '0;
                end
                else
                begin
                        scl_q  <= scl;
                        line_q <= line;
                        if (scl && scl_q && line_q && !line)
                        begin
                                st   <= M_DEV;      // start or repeated start
                                cnt  <= 4'hf;       // scl fall after start wraps it to 0
                                pull <= 1'b0;
                        end
                        else if (scl && scl_q && !line_q && line)
                        begin
                                st   <= M_IDLE;     // stop
                                pull <= 1'b0;
                        end
                        else if (scl && !scl_q)
                        begin
                                if (st inside {M_DEV, M_WORD, M_WDATA} && cnt < 8)
                                        sh <= {sh[6:0], line};
                                if (st == M_RDATA && cnt == 8)
                                        m_ack <= ~line;
                        end
                        else if (!scl && scl_q && st != M_IDLE)
                        begin
                                if (cnt == 8)
                                begin
                                        cnt  <= '0;
                                        pull <= 1'b0;
                                        case (st)
                                        M_DEV:
                                        begin
                                                if (rw)
                                                begin
                                                        st   <= M_RDATA;
                                                        tx   <= {mem[ptr][6:0], 1'b0};
                                                        pull <= ~mem[ptr][7];
                                                        ptr  <= ptr + 1'b1;
                                                end
                                                else
                                                        st <= M_WORD;
                                        end
                                        M_WORD: st <= M_WDATA;
                                        M_RDATA:
                                        begin
                                                if (m_ack)
                                                begin
                                                        tx   <= {mem[ptr][6:0], 1'b0};
                                                        pull <= ~mem[ptr][7];
                                                        ptr  <= ptr + 1'b1;
                                                end
                                                else
                                                        st <= M_IDLE;
                                        end
                                        default: ;
                                        endcase
                                end
                                else if (cnt == 7)
                                begin
                                        cnt <= 4'd8;
                                        case (st)
                                        M_DEV:
                                        begin
                                                if (sh[7:1] == `I2C_DEV_ADDR && !mute)
                                                begin
                                                        pull <= 1'b1;
                                                        rw   <= sh[0];
                                                end
                                                else
                                                        st <= M_IDLE;   // not addressed
                                        end
                                        M_WORD:
                                        begin
                                                ptr  <= sh;
                                                pull <= 1'b1;
                                        end
                                        M_WDATA:
                                        begin
                                                mem[ptr] <= sh;
                                                ptr      <= ptr + 1'b1;
                                                pull     <= 1'b1;
                                        end
                                        default: pull <= 1'b0;  // master acks
                                        endcase
                                end
                                else
                                begin
                                        cnt <= cnt + 1'b1;
                                        if (st == M_RDATA)
                                        begin
                                                pull <= ~tx[7];
                                                tx   <= {tx[6:0], 1'b0};
                                        end
                                end
                        end
                end
        end

endmodule

//--- tb_e2prom.sv
`include "eeprom_defs.svh"

module tb_e2prom;

        localparam int TIMEOUT = 40000;

        logic        clk;
        logic        rstn;
        logic        start;
        logic        wr;
        logic        rd;
        logic        mute;
        logic [7:0]  addr;
        logic [7:0]  data_wr;
        logic [15:0] data_rd;
        logic        done;
        logic        ack;
        logic        scl;
        logic        sda_o;
        logic        sda_oe;
        logic        sda_i;
        logic        started;
        logic        txn_begin;
        logic        cur_wr;
        logic [7:0]  cur_addr;
        logic [7:0]  next_addr;
        int          exp_acks;
        int          exp_starts;
        int          ack_cnt;
        int          start_cnt;
        int          stop_cnt;
        int          done_cnt;
        logic        scl_q;
        logic        sda_q;
        logic [7:0]  shadow [0:255];
        logic [7:0]  mem_at;
        logic [7:0]  shadow_at;
        logic [7:0]  shadow_nx;
        logic [7:0]  a;
        logic [7:0]  d;

        initial clk = 1'b0;
        always #20 clk = ~clk;

        e2prom_ctrl UUT (
                .clk(clk), .rstn(rstn), .start(start), .wr(wr), .rd(rd),
                .addr(addr), .data_wr(data_wr), .data_rd(data_rd), .done(done),
                .ack(ack), .scl(scl), .sda_o(sda_o), .sda_oe(sda_oe), .sda_i(sda_i)
        );

        eeprom_model eeprom (
                .clk(clk), .rstn(rstn), .mute(mute), .scl(scl),
                .sda_o(sda_o), .sda_oe(sda_oe), .sda_i(sda_i)
        );

        assign next_addr = cur_addr + 8'd1;
        assign mem_at    = eeprom.mem[cur_addr];
        assign shadow_at = shadow[cur_addr];
        assign shadow_nx = shadow[next_addr];

        task automatic report_failure(input string msg);
                $display("%s", msg);
                $display("TEST FAILED");
                $fatal(1);
        endtask

        // per-transaction event counters on the resolved bus
        always @(posedge clk)
        begin
                scl_q <= scl;
                sda_q <= sda_i;
                if (txn_begin)
                begin
                        ack_cnt   <= 0;
                        start_cnt <= 0;
                        stop_cnt  <= 0;
                        done_cnt  <= 0;
                end
                else if (rstn)
                begin
                        ack_cnt  <= ack_cnt + int'(ack);
                        done_cnt <= done_cnt + int'(done);
                        if (scl && scl_q && sda_q && !sda_i)
                                start_cnt <= start_cnt + 1;
                        if (scl && scl_q && !sda_q && sda_i)
                                stop_cnt <= stop_cnt + 1;
                end
        end

        a_reset_idle: assert property (@(posedge clk) disable iff (!rstn)
                !started |-> scl && sda_oe && sda_o && !done && !ack)
                else report_failure($sformatf("Mismatch idle scl/sda_oe/sda_o/done/ack: %h%h%h%h%h",
                        $sampled(scl), $sampled(sda_oe), $sampled(sda_o),
                        $sampled(done), $sampled(ack)));
        a_write_mem: assert property (@(posedge clk) disable iff (!rstn)
                done && cur_wr |-> mem_at == shadow_at)
                else report_failure($sformatf("Mismatch mem[%h]: got %h expected %h",
                        $sampled(cur_addr), $sampled(mem_at), $sampled(shadow_at)));
        a_read_data: assert property (@(posedge clk) disable iff (!rstn)
                done && !cur_wr |-> data_rd == {shadow_at, shadow_nx})
                else report_failure($sformatf("Mismatch data_rd: got %h expected %h",
                        $sampled(data_rd), {$sampled(shadow_at), $sampled(shadow_nx)}));
        a_ack_count: assert property (@(posedge clk) disable iff (!rstn)
                done |-> ack_cnt == exp_acks)
                else report_failure($sformatf("Mismatch ack_cnt: got %h expected %h",
                        $sampled(ack_cnt), $sampled(exp_acks)));
        a_start_count: assert property (@(posedge clk) disable iff (!rstn)
                done |-> start_cnt == exp_starts)
                else report_failure($sformatf("Mismatch start_cnt: got %h expected %h",
                        $sampled(start_cnt), $sampled(exp_starts)));
        a_stop_count: assert property (@(posedge clk) disable iff (!rstn)
                done |-> stop_cnt == 1)
                else report_failure($sformatf("Mismatch stop_cnt: got %h expected %h",
                        $sampled(stop_cnt), 1));
        a_one_done: assert property (@(posedge clk) disable iff (!rstn)
                done |-> done_cnt == 0)
                else report_failure($sformatf("Mismatch done_cnt: got %h expected %h",
                        $sampled(done_cnt), 0));

        task automatic run_txn(input bit do_wr, input logic [7:0] ta, input logic [7:0] td,
                               input bit muted, input bit extra_start);
                int cnt;
                cnt = 0;
                @(posedge clk);
                start      <= 1'b1;
                wr         <= do_wr;
                rd         <= !do_wr;
                addr       <= ta;
                data_wr    <= td;
                mute       <= muted;
                txn_begin  <= 1'b1;
                started    <= 1'b1;
                cur_wr     <= do_wr;
                cur_addr   <= ta;
                exp_acks   <= muted ? 0 : 3;
                exp_starts <= do_wr ? 1 : 2;
                if (do_wr && !muted)
                        shadow[ta] <= td;
                do
                begin
                        @(posedge clk);
                        start     <= extra_start && cnt == 500;  // ignored mid-transaction
                        txn_begin <= 1'b0;
                        @(negedge clk);
                        cnt++;
                end
                while (!done && cnt < TIMEOUT);
                if (!done)
                        report_failure("timeout, no done pulse from the controller");
                repeat (240 * `I2C_STEP_DIV) @(negedge clk);    // a whole read fits in here
                assert (done_cnt == 1)
                        else report_failure("a transaction produced more than one done pulse");
        endtask

        initial
        begin
                void'($urandom(79216));
                rstn      = 1'b0;
                start     = 1'b0;
                wr        = 1'b0;
                rd        = 1'b0;
                mute      = 1'b0;
                addr      = '0;
                data_wr   = '0;
                started   = 1'b0;
                txn_begin = 1'b0;
                cur_wr    = 1'b0;
                cur_addr  = '0;
                for (int i = 0; i < 256; i++)
                        shadow[i] = {i[3:0], i[7:4]} ^ 8'ha5;
                repeat (16) @(posedge clk);
                rstn <= 1'b1;
                repeat (100) @(posedge clk);
                for (int i = 0; i < 4; i++)
                begin
                        a = 8'($urandom);
                        d = 8'($urandom);
                        run_txn(1'b1, a, d, 1'b0, 1'b0);
                end
                run_txn(1'b0, a - 8'd1, 8'h00, 1'b0, 1'b0);     // covers the last write
                run_txn(1'b0, 8'($urandom), 8'h00, 1'b0, 1'b0);
                run_txn(1'b0, 8'hff, 8'h00, 1'b0, 1'b0);        // address wraps
                a = 8'($urandom);
                run_txn(1'b1, a, 8'($urandom), 1'b1, 1'b0);     // no device answers
                run_txn(1'b1, a, 8'($urandom), 1'b0, 1'b1);
                run_txn(1'b0, a, 8'h00, 1'b0, 1'b1);
                $display("TEST OK");
                $finish;
        end

endmodule

//--- build.f
+incdir+.
i2c_pkg.sv
i2c_byte_if.sv
i2c_sequencer.sv
i2c_bit_engine.sv
e2prom_ctrl.sv
eeprom_model.sv
tb_e2prom.sv

//--- Makefile
SRCS := $(filter-out +incdir+%,$(shell cat build.f)) eeprom_defs.svh

.PHONY: all run clean

all: obj_dir/Vtb_e2prom

obj_dir/Vtb_e2prom: build.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f build.f --top-module tb_e2prom -o Vtb_e2prom

run: obj_dir/Vtb_e2prom
	./obj_dir/Vtb_e2prom 2>&1 | tee sim.log
	grep -q "^TEST OK$$" sim.log

clean:
	rm -rf obj_dir sim.log
